/* include/bpm_defs.svh */
`ifndef BPM_DEFS_SVH
`define BPM_DEFS_SVH

////////////////////
// Widths
////////////////////
`define BPM_BUS_W        32
`define BPM_DATA_W       16
`define BPM_GAIN_W       5   // VGA gain code
`define BPM_ATT_W        6   // Step attenuator setting
`define BPM_ATT_LSB      8   // Attenuator field position in AFE control
`define BPM_ATT_CNT_W    3   // Holds ATT_W-1

`define BPM_FPGA_VERSION 32'h0003_0102

////////////////////
// Register map
////////////////////
`define BPM_BASE_ADDR    32'h4171_0000

// Byte offsets, word index times four
`define BPM_REG_STATUS   (32'd4 * 32'h0000)
`define BPM_REG_CONTROL  (32'd4 * 32'h0001)
`define BPM_REG_VERSION  (32'd4 * 32'h0002)
`define BPM_REG_POWER_A  (32'd4 * 32'h0004)
`define BPM_REG_POWER_B  (32'd4 * 32'h0005)
`define BPM_REG_POWER_C  (32'd4 * 32'h0006)
`define BPM_REG_POWER_D  (32'd4 * 32'h0007)
`define BPM_REG_POS_X    (32'd4 * 32'h0008)
`define BPM_REG_POS_Y    (32'd4 * 32'h0009)
`define BPM_REG_POS_S    (32'd4 * 32'h000A)
`define BPM_REG_TRIG_DL  (32'd4 * 32'h0016)
`define BPM_REG_BPM_DIA  (32'd4 * 32'h0017)
`define BPM_REG_TRIG_TH  (32'd4 * 32'h0018)
`define BPM_REG_TRIG_DT  (32'd4 * 32'h0019)
`define BPM_REG_EVT_LEN  (32'd4 * 32'h001A)
`define BPM_REG_EVT_TAIL (32'd4 * 32'h001B)
`define BPM_REG_BL_LEN   (32'd4 * 32'h001C)
`define BPM_REG_AFE_CTRL (32'd4 * 32'h0058)
`define BPM_REG_VGA_GAIN (32'd4 * 32'h006D)

// Control register bits
`define BPM_CTRL_SOFT_RESET   15
`define BPM_CTRL_PICKUP_FORCE 13
`define BPM_CTRL_AUTO_RANGE   6
`define BPM_CTRL_SMA_ENABLE   3

`endif

/* design/bpm_pkg.sv */
`default_nettype none
`include "bpm_defs.svh"

package bpm_pkg;

	////////////////////
	// Processor bus
	////////////////////
	typedef struct packed {
		logic                   en;
		logic [3:0]             we;      // Byte write strobes
		logic [`BPM_BUS_W-1:0]  addr;
		logic [`BPM_BUS_W-1:0]  wr_data;
	} bus_req_t;

	typedef enum logic [1:0] {
		bus_idle,
		bus_read,
		bus_write
	} bus_op_e;

	// Results from the processing chain
	typedef struct packed {
		logic [`BPM_DATA_W-1:0]       status;
		logic [`BPM_DATA_W-1:0]       x;
		logic [`BPM_DATA_W-1:0]       y;
		logic [`BPM_DATA_W-1:0]       s;
		logic [3:0][`BPM_BUS_W-1:0]   power;   // Index 0 is channel A
	} proc_result_t;

	// Settings for the processing chain
	typedef struct packed {
		logic [`BPM_DATA_W-1:0] bpm_dia;
		logic [`BPM_DATA_W-1:0] trig_th;
		logic [`BPM_DATA_W-1:0] trig_dt;
		logic [`BPM_DATA_W-1:0] trig_dl;
		logic [`BPM_DATA_W-1:0] evt_len;
		logic [`BPM_DATA_W-1:0] evt_tail_len;
		logic [`BPM_DATA_W-1:0] bl_len;
	} proc_cfg_t;

	typedef struct packed {
		logic soft_reset;
		logic pickup_force;
		logic auto_range;     // 1 = VGA gain from auto-range input
		logic sma_enable;
	} ctrl_bits_t;

	// Attenuator serial loader
	typedef enum logic [1:0] {
		att_idle,
		att_shift_low,
		att_shift_high,
		att_latch
	} att_state_e;

endpackage

`default_nettype wire

/* design/bpm_reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bpm_defs.svh"

module bpm_reg_bank (
	input  logic                      clk,
	input  logic                      reset,
	input  bpm_pkg::bus_req_t         bus,
	input  bpm_pkg::proc_result_t     results,
	input  logic [`BPM_GAIN_W-1:0]    vga_gain,
	output logic [`BPM_BUS_W-1:0]     rd_data,
	output bpm_pkg::proc_cfg_t        cfg,
	output bpm_pkg::ctrl_bits_t       ctrl,
	output logic [`BPM_DATA_W-1:0]    afe_ctrl,
	output logic                      sub_reset
);

	logic [`BPM_DATA_W-1:0] control_reg;
	bpm_pkg::bus_op_e       op;
	logic [`BPM_BUS_W-1:0]  offset;     // Relative to base address
	logic [`BPM_BUS_W-1:0]  rd_next;
	logic                   rd_hit;

	function automatic logic [`BPM_BUS_W-1:0] sext(input logic [`BPM_DATA_W-1:0] v);
		return {{(`BPM_BUS_W-`BPM_DATA_W){v[`BPM_DATA_W-1]}}, v};
	endfunction

	function automatic logic [`BPM_BUS_W-1:0] zext(input logic [`BPM_DATA_W-1:0] v);
		return {{(`BPM_BUS_W-`BPM_DATA_W){1'b0}}, v};
	endfunction

	////////////////////
	// Bus decode
	////////////////////
	always_comb begin
		if (!bus.en)
			op = bpm_pkg::bus_idle;
		else if (bus.we == 4'hf)
			op = bpm_pkg::bus_write;
		else if (bus.we == 4'h0)
			op = bpm_pkg::bus_read;
		else
			op = bpm_pkg::bus_idle;    // Partial byte writes are ignored
	end

	assign offset = bus.addr - `BPM_BASE_ADDR;

	assign ctrl.soft_reset   = control_reg[`BPM_CTRL_SOFT_RESET];
	assign ctrl.pickup_force = control_reg[`BPM_CTRL_PICKUP_FORCE];
	assign ctrl.auto_range   = control_reg[`BPM_CTRL_AUTO_RANGE];
	assign ctrl.sma_enable   = control_reg[`BPM_CTRL_SMA_ENABLE];

	////////////////////
	// Read mux
	////////////////////
	always_comb begin
		rd_hit  = 1'b1;
		rd_next = '0;
		case (offset)
			`BPM_REG_STATUS:   rd_next = sext(results.status);
			`BPM_REG_CONTROL:  rd_next = sext(control_reg);
			`BPM_REG_VERSION:  rd_next = `BPM_FPGA_VERSION;
			`BPM_REG_POWER_A:  rd_next = results.power[0];
			`BPM_REG_POWER_B:  rd_next = results.power[1];
			`BPM_REG_POWER_C:  rd_next = results.power[2];
			`BPM_REG_POWER_D:  rd_next = results.power[3];
			`BPM_REG_POS_X:    rd_next = zext(results.x);
			`BPM_REG_POS_Y:    rd_next = zext(results.y);
			`BPM_REG_POS_S:    rd_next = zext(results.s);
			`BPM_REG_TRIG_DL:  rd_next = zext(cfg.trig_dl);
			`BPM_REG_BPM_DIA:  rd_next = zext(cfg.bpm_dia);
			`BPM_REG_TRIG_TH:  rd_next = zext(cfg.trig_th);
			`BPM_REG_TRIG_DT:  rd_next = zext(cfg.trig_dt);
			`BPM_REG_EVT_LEN:  rd_next = zext(cfg.evt_len);
			`BPM_REG_EVT_TAIL: rd_next = zext(cfg.evt_tail_len);
			`BPM_REG_BL_LEN:   rd_next = zext(cfg.bl_len);
			`BPM_REG_AFE_CTRL: rd_next = sext(afe_ctrl);
			`BPM_REG_VGA_GAIN: rd_next = {{(`BPM_BUS_W-`BPM_GAIN_W){1'b0}}, vga_gain};
			default:           rd_hit  = 1'b0;
		endcase
	end

	////////////////////
	// Register storage
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			control_reg <= '0;
			afe_ctrl    <= '0;
			cfg         <= '0;
			rd_data     <= '0;
		end else begin
			if (op == bpm_pkg::bus_write) begin
				case (offset)
					`BPM_REG_CONTROL:  control_reg      <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_TRIG_DL:  cfg.trig_dl      <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_BPM_DIA:  cfg.bpm_dia      <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_TRIG_TH:  cfg.trig_th      <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_TRIG_DT:  cfg.trig_dt      <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_EVT_LEN:  cfg.evt_len      <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_EVT_TAIL: cfg.evt_tail_len <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_BL_LEN:   cfg.bl_len       <= bus.wr_data[`BPM_DATA_W-1:0];
					`BPM_REG_AFE_CTRL: afe_ctrl         <= bus.wr_data[`BPM_DATA_W-1:0];
					default: ;                          // Read-only or unmapped
				endcase
			end
			// Undecoded reads keep the last value
			if (op == bpm_pkg::bus_read && rd_hit)
				rd_data <= rd_next;
		end
	end

	// Subsystem reset for the AFE and attenuator blocks
	always_ff @(posedge clk) begin
		if (reset)
			sub_reset <= 1'b1;
		else
			sub_reset <= ctrl.soft_reset;
	end

endmodule

`default_nettype wire

/* design/afe_control.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bpm_defs.svh"

module afe_control (
	input  logic                    clk,
	input  logic                    sub_reset,
	input  bpm_pkg::ctrl_bits_t     ctrl,
	input  logic [`BPM_DATA_W-1:0]  afe_ctrl,
	input  logic [`BPM_GAIN_W-1:0]  auto_att,
	input  logic                    trig,
	input  logic                    cal_on,
	output logic                    afe_pickup,
	output logic                    afe_cal,
	output logic                    sma_out,
	output logic [`BPM_GAIN_W-1:0]  vga_gain
);

	logic                   pickup_next;
	logic [`BPM_GAIN_W-1:0] gain_next;

	// Forced pickup overrides the calibration sequencer
	assign pickup_next = ctrl.pickup_force | cal_on;

	// Manual gain sits in the low bits of AFE control
	assign gain_next = ctrl.auto_range ? auto_att : afe_ctrl[`BPM_GAIN_W-1:0];

	////////////////////
	// Output registers
	////////////////////
	always_ff @(posedge clk) begin
		if (sub_reset) begin
			afe_pickup <= 1'b0;      // Signal path selected
			afe_cal    <= 1'b1;      // Cal source off
			sma_out    <= 1'b1;
			vga_gain   <= '0;
		end else begin
			afe_pickup <= pickup_next;
			afe_cal    <= ~pickup_next;
			vga_gain   <= gain_next;
			// External NAND gate on the SMA path, so drive inverted
			if (ctrl.sma_enable)
				sma_out <= ~trig;
			else
				sma_out <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/att_serial_loader.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bpm_defs.svh"

module att_serial_loader (
	input  logic                   clk,
	input  logic                   sub_reset,
	input  logic [`BPM_ATT_W-1:0]  setting,
	output logic                   att_le,
	output logic                   att_clk,
	output logic                   att_data
);

	bpm_pkg::att_state_e       state;
	logic [`BPM_ATT_CNT_W-1:0] bit_cnt;     // Bits left after the current one
	logic [`BPM_ATT_W-1:0]     shift_reg;
	logic [`BPM_ATT_W-1:0]     last_sent;
	logic                      pending;
	logic                      changed;
	logic                      start;

	assign changed = (setting != last_sent);
	assign start   = (state == bpm_pkg::att_idle) && (pending || changed);

	// Pins decode straight from the state register
	assign att_clk  = (state == bpm_pkg::att_shift_high);
	assign att_le   = (state == bpm_pkg::att_latch);
	assign att_data = shift_reg[`BPM_ATT_W-1];    // MSB first

	////////////////////
	// Transfer FSM
	////////////////////
	always_ff @(posedge clk) begin
		if (sub_reset) begin
			state   <= bpm_pkg::att_idle;
			bit_cnt <= '0;
			pending <= 1'b1;                      // Nothing sent yet
		end else begin
			case (state)
				bpm_pkg::att_idle: begin
					if (start) begin
						state   <= bpm_pkg::att_shift_low;
						bit_cnt <= `BPM_ATT_CNT_W'(`BPM_ATT_W - 1);
						pending <= 1'b0;
					end
				end
				bpm_pkg::att_shift_low:
					state <= bpm_pkg::att_shift_high;    // Clock rises
				bpm_pkg::att_shift_high: begin
					if (bit_cnt == '0) begin
						state <= bpm_pkg::att_latch;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
						state   <= bpm_pkg::att_shift_low;
					end
				end
				bpm_pkg::att_latch:
					state <= bpm_pkg::att_idle;
				default:
					state <= bpm_pkg::att_idle;
			endcase
			// New setting arrived mid-transfer, resend after the latch
			if (state != bpm_pkg::att_idle && changed)
				pending <= 1'b1;
		end
	end

	// Shift data
	always_ff @(posedge clk) begin
		if (start) begin
			shift_reg <= setting;
			last_sent <= setting;
		end else if (state == bpm_pkg::att_shift_high) begin
			shift_reg <= {shift_reg[`BPM_ATT_W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* design/bpm_ctrl_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bpm_defs.svh"

module bpm_ctrl_top (
	input  logic                    clk,
	input  logic                    reset,
	input  bpm_pkg::bus_req_t       bus,
	input  bpm_pkg::proc_result_t   results,
	input  logic [`BPM_GAIN_W-1:0]  auto_att,
	input  logic                    trig,
	input  logic                    cal_on,
	output logic [`BPM_BUS_W-1:0]   rd_data,
	output bpm_pkg::proc_cfg_t      cfg,
	output logic                    afe_pickup,
	output logic                    afe_cal,
	output logic [`BPM_GAIN_W-1:0]  vga_gain,
	output logic                    sma_out,
	output logic                    att_le,
	output logic                    att_clk,
	output logic                    att_data
);

	bpm_pkg::ctrl_bits_t     ctrl;
	logic [`BPM_DATA_W-1:0]  afe_ctrl;
	logic                    sub_reset;

	////////////////////
	// Register bank
	////////////////////
	bpm_reg_bank i_reg_bank (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus),
		.results   (results),
		.vga_gain  (vga_gain),    // Actual gain readback
		.rd_data   (rd_data),
		.cfg       (cfg),
		.ctrl      (ctrl),
		.afe_ctrl  (afe_ctrl),
		.sub_reset (sub_reset)
	);

	////////////////////
	// AFE outputs
	////////////////////
	afe_control i_afe_control (
		.clk        (clk),
		.sub_reset  (sub_reset),
		.ctrl       (ctrl),
		.afe_ctrl   (afe_ctrl),
		.auto_att   (auto_att),
		.trig       (trig),
		.cal_on     (cal_on),
		.afe_pickup (afe_pickup),
		.afe_cal    (afe_cal),
		.sma_out    (sma_out),
		.vga_gain   (vga_gain)
	);

	// Step attenuator, setting from AFE control bits 13..8
	att_serial_loader i_att_loader (
		.clk       (clk),
		.sub_reset (sub_reset),
		.setting   (afe_ctrl[`BPM_ATT_LSB +: `BPM_ATT_W]),
		.att_le    (att_le),
		.att_clk   (att_clk),
		.att_data  (att_data)
	);

endmodule

`default_nettype wire

/* testbench/bpm_ctrl_props.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bpm_defs.svh"

module bpm_ctrl_props (
	input logic                   clk,
	input logic                   reset,
	input logic                   sub_reset,
	input logic                   afe_pickup,
	input logic                   afe_cal,
	input logic                   sma_out,
	input logic [`BPM_GAIN_W-1:0] vga_gain,
	input logic                   att_le,
	input logic                   att_clk
);

	le_single: assert property (@(posedge clk) disable iff (reset) att_le |=> !att_le)
		else $error("att_le stayed high for more than one cycle");

	// Cal source only when the signal path is off
	cal_inverse: assert property (@(posedge clk) disable iff (reset) afe_cal == !afe_pickup)
		else $error("afe_cal is not the inverse of afe_pickup");

	sub_reset_values: assert property (@(posedge clk) disable iff (reset)
		sub_reset |=> (!afe_pickup && afe_cal && sma_out && vga_gain == '0 && !att_le && !att_clk))
		else $error("Outputs left their reset values after sub_reset");

endmodule

bind bpm_ctrl_top bpm_ctrl_props i_props (
	.clk        (clk),
	.reset      (reset),
	.sub_reset  (sub_reset),
	.afe_pickup (afe_pickup),
	.afe_cal    (afe_cal),
	.sma_out    (sma_out),
	.vga_gain   (vga_gain),
	.att_le     (att_le),
	.att_clk    (att_clk)
);

`default_nettype wire

/* testbench/tb_bpm_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bpm_defs.svh"

module tb_bpm_ctrl;

	typedef struct packed {
		logic                   pickup;
		logic                   cal;
		logic                   sma;
		logic [`BPM_GAIN_W-1:0] gain;
	} afe_out_t;

	localparam int num_random     = 2000;
	localparam int planned_cycles = 8 + num_random + 100;
	localparam int timeout_cycles = 3 * planned_cycles;
	localparam int att_cycles     = 2 * `BPM_ATT_W + 1;    // Six bits plus latch
	localparam int num_regs       = 19;
	localparam logic [31:0] reg_offsets [num_regs] = '{
		`BPM_REG_STATUS, `BPM_REG_CONTROL, `BPM_REG_VERSION, `BPM_REG_POWER_A,
		`BPM_REG_POWER_B, `BPM_REG_POWER_C, `BPM_REG_POWER_D, `BPM_REG_POS_X,
		`BPM_REG_POS_Y, `BPM_REG_POS_S, `BPM_REG_TRIG_DL, `BPM_REG_BPM_DIA,
		`BPM_REG_TRIG_TH, `BPM_REG_TRIG_DT, `BPM_REG_EVT_LEN, `BPM_REG_EVT_TAIL,
		`BPM_REG_BL_LEN, `BPM_REG_AFE_CTRL, `BPM_REG_VGA_GAIN};

	logic                   clk = 1'b0;
	logic                   reset;
	bpm_pkg::bus_req_t      bus;
	bpm_pkg::proc_result_t  results;
	logic [`BPM_GAIN_W-1:0] auto_att, vga_gain;
	logic                   trig, cal_on;
	logic [`BPM_BUS_W-1:0]  rd_data;
	bpm_pkg::proc_cfg_t     cfg;
	logic                   afe_pickup, afe_cal, sma_out;
	logic                   att_le, att_clk, att_data;

	// Reference model, state after the last rising edge
	logic [`BPM_DATA_W-1:0] m_control, m_afe_ctrl;
	bpm_pkg::proc_cfg_t     m_cfg;
	logic [`BPM_BUS_W-1:0]  m_rd;
	logic                   m_sub_reset;
	afe_out_t               m_afe;

	logic [`BPM_ATT_W-1:0]  att_hist [att_cycles];   // Setting per cycle, oldest first
	logic [`BPM_ATT_W-1:0]  att_bits, att_last;
	logic                   prev_att_clk;
	int                     att_nbits, att_count, att_base;
	integer                 seed;
	int                     cycle_count;

	bpm_ctrl_top i_dut (
		.clk(clk), .reset(reset), .bus(bus), .results(results), .auto_att(auto_att),
		.trig(trig), .cal_on(cal_on), .rd_data(rd_data), .cfg(cfg),
		.afe_pickup(afe_pickup), .afe_cal(afe_cal), .vga_gain(vga_gain),
		.sma_out(sma_out), .att_le(att_le), .att_clk(att_clk), .att_data(att_data)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			abort_run($sformatf("Timeout after %0d cycles", cycle_count));
	end

	////////////////////
	// Checking
	////////////////////
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [`BPM_BUS_W-1:0] act, exp);
		if (act !== exp)
			abort_run($sformatf("Mismatch %s: got %h, expected %h", name, act, exp));
	endtask

	task automatic check_cfg(input bpm_pkg::proc_cfg_t act, exp);
		if (act !== exp)
			abort_run($sformatf("Mismatch cfg: got %h, expected %h", act, exp));
	endtask

	task automatic check_afe(input afe_out_t act, exp);
		if (act !== exp)
			abort_run($sformatf("Mismatch afe outputs: got %h, expected %h", act, exp));
	endtask

	task automatic check_att(input logic [`BPM_ATT_W-1:0] act, exp);
		if (act !== exp)
			abort_run($sformatf("Mismatch att_data word: got %h, expected %h", act, exp));
	endtask

	// Collects bits on att_clk rising, compares at each latch
	task automatic track_att();
		if (att_clk && !prev_att_clk) begin
			att_bits  = {att_bits[`BPM_ATT_W-2:0], att_data};
			att_nbits = att_nbits + 1;
		end
		prev_att_clk = att_clk;
		if (att_le) begin
			if (att_nbits != `BPM_ATT_W)
				abort_run($sformatf("Attenuator latched after %0d clock pulses", att_nbits));
			check_att(att_bits, att_hist[0]);
			att_last  = att_bits;
			att_count = att_count + 1;
			att_nbits = 0;
		end
		if (m_sub_reset)
			att_nbits = 0;                       // Transfer aborted
		for (int k = 0; k < att_cycles - 1; k++)
			att_hist[k] = att_hist[k + 1];
		att_hist[att_cycles - 1] = m_afe_ctrl[`BPM_ATT_LSB +: `BPM_ATT_W];
	endtask

	////////////////////
	// Reference model
	////////////////////
	function automatic logic read_map(input logic [31:0] off, output logic [31:0] val);
		read_map = 1'b1;
		val      = '0;
		case (off)
			`BPM_REG_STATUS:   val = {{16{results.status[15]}}, results.status};
			`BPM_REG_CONTROL:  val = {{16{m_control[15]}}, m_control};
			`BPM_REG_VERSION:  val = `BPM_FPGA_VERSION;
			`BPM_REG_POWER_A:  val = results.power[0];
			`BPM_REG_POWER_B:  val = results.power[1];
			`BPM_REG_POWER_C:  val = results.power[2];
			`BPM_REG_POWER_D:  val = results.power[3];
			`BPM_REG_POS_X:    val = {16'h0, results.x};
			`BPM_REG_POS_Y:    val = {16'h0, results.y};
			`BPM_REG_POS_S:    val = {16'h0, results.s};
			`BPM_REG_TRIG_DL:  val = {16'h0, m_cfg.trig_dl};
			`BPM_REG_BPM_DIA:  val = {16'h0, m_cfg.bpm_dia};
			`BPM_REG_TRIG_TH:  val = {16'h0, m_cfg.trig_th};
			`BPM_REG_TRIG_DT:  val = {16'h0, m_cfg.trig_dt};
			`BPM_REG_EVT_LEN:  val = {16'h0, m_cfg.evt_len};
			`BPM_REG_EVT_TAIL: val = {16'h0, m_cfg.evt_tail_len};
			`BPM_REG_BL_LEN:   val = {16'h0, m_cfg.bl_len};
			`BPM_REG_AFE_CTRL: val = {{16{m_afe_ctrl[15]}}, m_afe_ctrl};
			`BPM_REG_VGA_GAIN: val = {{(`BPM_BUS_W-`BPM_GAIN_W){1'b0}}, m_afe.gain};
			default:           read_map = 1'b0;
		endcase
	endfunction

	// Advances the model over one rising edge with the inputs now driven
	task automatic model_step(input bpm_pkg::bus_req_t req);
		logic [31:0] off;
		logic [31:0] rv;
		logic        hit;
		off = req.addr - `BPM_BASE_ADDR;
		hit = read_map(off, rv);
		if (req.en && req.we == 4'h0 && hit)
			m_rd = rv;
		if (m_sub_reset) begin
			m_afe = '{pickup: 1'b0, cal: 1'b1, sma: 1'b1, gain: '0};
		end else begin
			m_afe.pickup = m_control[`BPM_CTRL_PICKUP_FORCE] | cal_on;
			m_afe.cal    = ~m_afe.pickup;
			m_afe.sma    = m_control[`BPM_CTRL_SMA_ENABLE] ? ~trig : 1'b1;
			m_afe.gain   = m_control[`BPM_CTRL_AUTO_RANGE] ? auto_att : m_afe_ctrl[4:0];
		end
		m_sub_reset = m_control[`BPM_CTRL_SOFT_RESET];
		if (req.en && req.we == 4'hf) begin
			case (off)
				`BPM_REG_CONTROL:  m_control          = req.wr_data[15:0];
				`BPM_REG_TRIG_DL:  m_cfg.trig_dl      = req.wr_data[15:0];
				`BPM_REG_BPM_DIA:  m_cfg.bpm_dia      = req.wr_data[15:0];
				`BPM_REG_TRIG_TH:  m_cfg.trig_th      = req.wr_data[15:0];
				`BPM_REG_TRIG_DT:  m_cfg.trig_dt      = req.wr_data[15:0];
				`BPM_REG_EVT_LEN:  m_cfg.evt_len      = req.wr_data[15:0];
				`BPM_REG_EVT_TAIL: m_cfg.evt_tail_len = req.wr_data[15:0];
				`BPM_REG_BL_LEN:   m_cfg.bl_len       = req.wr_data[15:0];
				`BPM_REG_AFE_CTRL: m_afe_ctrl         = req.wr_data[15:0];
				default: ;
			endcase
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////
	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	function automatic bpm_pkg::bus_req_t make_req(input logic en, input logic [3:0] we,
			input logic [31:0] off, input logic [31:0] data);
		make_req = '{en: en, we: we, addr: `BPM_BASE_ADDR + off, wr_data: data};
	endfunction

	function automatic bpm_pkg::bus_req_t random_req();
		logic [31:0] r;
		logic [31:0] off;
		logic [31:0] data;
		int          idx;
		r = rand32();
		if (r[2:0] != 3'd0) begin
			idx = int'(rand32() % 32'd19);
			off = reg_offsets[idx];
		end else if (r[3]) begin
			off = (rand32() & 32'h1ff) << 2;     // Word inside the window
		end else begin
			off = rand32();
		end
		data = rand32();
		if (off == `BPM_REG_CONTROL && r[5:4] != 2'd0)
			data[`BPM_CTRL_SOFT_RESET] = 1'b0;   // Soft reset only now and then
		if (r[11:8] < 4'd6)
			random_req = make_req(1'b1, 4'hf, off, data);
		else if (r[11:8] < 4'd12)
			random_req = make_req(1'b1, 4'h0, off, data);
		else if (r[11:8] == 4'd12)
			random_req = make_req(1'b1, 4'h3, off, data);   // Partial strobes
		else
			random_req = make_req(1'b0, r[15:12], off, data);
	endfunction

	// Checks the current outputs, then drives the next cycle at the falling edge
	task automatic run_cycle(input bpm_pkg::bus_req_t req);
		logic [31:0] r;
		check_word("rd_data", rd_data, m_rd);
		check_cfg(cfg, m_cfg);
		check_afe({afe_pickup, afe_cal, sma_out, vga_gain}, m_afe);
		track_att();
		r = rand32();
		if (r[0]) begin
			results.status = 16'(rand32());
			results.x      = 16'(rand32());
			results.y      = 16'(rand32());
			results.s      = 16'(rand32());
			for (int k = 0; k < 4; k++)
				results.power[k] = rand32();
		end
		if (r[3:1] == 3'd0)
			auto_att = r[12:8];
		trig = r[4];
		if (r[7:5] == 3'd0)
			cal_on = ~cal_on;
		reset = 1'b0;
		bus   = req;
		model_step(req);
		@(negedge clk);
	endtask

	initial begin
		seed        = 32'hf51fb58d;
		reset       = 1'b1;
		bus         = '0;
		results     = '0;
		auto_att    = '0;
		trig        = 1'b0;
		cal_on      = 1'b0;
		m_control   = '0;
		m_afe_ctrl  = '0;
		m_cfg       = '0;
		m_rd        = '0;
		m_sub_reset = 1'b1;
		m_afe       = '{pickup: 1'b0, cal: 1'b1, sma: 1'b1, gain: '0};
		prev_att_clk = 1'b0;
		att_bits    = '0;
		att_last    = '0;
		att_nbits   = 0;
		att_count   = 0;
		for (int k = 0; k < att_cycles; k++)
			att_hist[k] = '0;
		repeat (8) @(negedge clk);

		for (int i = 0; i < num_random; i++)
			run_cycle(random_req());

		// Soft reset keeps the registers, then restarts the attenuator
		run_cycle(make_req(1'b1, 4'hf, `BPM_REG_AFE_CTRL, 32'h0000_2a13));
		run_cycle(make_req(1'b1, 4'hf, `BPM_REG_CONTROL, 32'h0000_8048));
		repeat (4) run_cycle(make_req(1'b0, 4'h0, 32'h0, 32'h0));
		for (int k = 0; k < num_regs; k++)
			run_cycle(make_req(1'b1, 4'h0, reg_offsets[k], 32'h0));
		run_cycle(make_req(1'b1, 4'hf, `BPM_REG_CONTROL, 32'h0000_0000));
		att_base = att_count;
		while (att_count == att_base || att_last !== m_afe_ctrl[`BPM_ATT_LSB +: `BPM_ATT_W]
				|| att_clk || att_le)
			run_cycle(make_req(1'b0, 4'h0, 32'h0, 32'h0));
		run_cycle(make_req(1'b1, 4'h0, `BPM_REG_AFE_CTRL, 32'h0));
		run_cycle(make_req(1'b0, 4'h0, 32'h0, 32'h0));
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
design/bpm_pkg.sv
design/bpm_reg_bank.sv
design/afe_control.sv
design/att_serial_loader.sv
design/bpm_ctrl_top.sv
testbench/bpm_ctrl_props.sv
testbench/tb_bpm_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bpm_ctrl
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
